// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_wb_mem_subsystem
FILELIST := compile.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG)
	cat $(LOG)
	! grep -q "Simulation finished: FAIL" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/tb_wb_tasks.svh
// Bus-master tasks: idle request, beat drive, bounded ack wait, single accesses, code burst

// Request with every field at rest, no cycle and no strobe
function automatic wb_mem_pkg::wb_req_t idle_req();
        return '0;
endfunction

// Puts one beat on the code or the data port
task automatic drive_beat(input logic on_data, input logic wen, input logic [31:0] adr,
                          input logic [3:0] sel, input logic [31:0] dat,
                          input wb_mem_pkg::wb_cti_e cti);
        wb_mem_pkg::wb_req_t req;
        req = '{cyc: 1'b1, stb: 1'b1, wen: wen, sel: sel, adr: adr, dat: dat, cti: cti};
        if (on_data)
                data_req = req;
        else
                code_req = req;
endtask

// Takes cyc and stb away from one port
task automatic release_port(input logic on_data);
        if (on_data)
                data_req = idle_req();
        else
                code_req = idle_req();
endtask

// Samples the port on each falling edge until ack shows up or the limit runs out
// The acks are registered in the DUT, so sampling right after a drive is safe
task automatic wait_for_ack(input logic on_data, output logic [31:0] rdat, output logic err);
        wb_mem_pkg::wb_rsp_t rsp;
        int                  cycles;
        cycles = 0;
        rsp    = on_data ? data_rsp : code_rsp;
        while (!rsp.ack && cycles < ACK_TIMEOUT)
        begin
                @(negedge clk);
                cycles++;
                rsp = on_data ? data_rsp : code_rsp;
        end
        if (!rsp.ack)
        begin
                $display("timeout on the %s port, no ack after %0d cycles",
                         on_data ? "data" : "code", ACK_TIMEOUT);
                hung = 1'b1;
                errors++;
        end
        rdat = rsp.rdat;
        err  = rsp.err;
endtask

// Classic access, tagged end of burst; the request drops on the edge after the ack
task automatic single_access(input logic on_data, input logic wen, input logic [31:0] adr,
                             input logic [3:0] sel, input logic [31:0] dat,
                             output logic [31:0] rdat, output logic err);
        rdat = '0;
        err  = 1'b1;
        if (!hung)
        begin
                drive_beat(on_data, wen, adr, sel, dat, wb_mem_pkg::CTI_EOB);
                wait_for_ack(on_data, rdat, err);
                // The beat transfers on the rising edge while ack is high
                @(negedge clk);
                release_port(on_data);
        end
endtask

task automatic code_access(input logic wen, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat, output logic [31:0] rdat, output logic err);
        single_access(1'b0, wen, adr, sel, dat, rdat, err);
endtask

task automatic data_access(input logic wen, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat, output logic [31:0] rdat, output logic err);
        single_access(1'b1, wen, adr, sel, dat, rdat, err);
endtask

// Incrementing burst on the code port, the last beat carries end of burst
task automatic code_burst(input logic wen, input logic [31:0] adr,
                          input logic [BURST_LEN-1:0][31:0] wdat,
                          output logic [BURST_LEN-1:0][31:0] rdat,
                          output logic err, output time eob_time);
        logic [31:0]         beat_rdat;
        logic                beat_err;
        wb_mem_pkg::wb_cti_e cti;
        rdat     = '0;
        err      = hung;
        eob_time = 0;
        for (int i = 0; i < BURST_LEN && !hung; i++)
        begin
                if (i == BURST_LEN - 1)
                        cti = wb_mem_pkg::CTI_EOB;
                else
                        cti = wb_mem_pkg::CTI_INCR;
                // Next address goes out on the cycle right after each ack
                drive_beat(1'b0, wen, adr + 32'(4 * i), 4'hf, wdat[i], cti);
                wait_for_ack(1'b0, beat_rdat, beat_err);
                rdat[i]  = beat_rdat;
                err      = err | beat_err;
                eob_time = $time;
                @(negedge clk);
        end
        release_port(1'b0);
endtask

// File: bench/tb_wb_mem_subsystem.sv
// Testbench top with clock, reset, DUT, byte-lane scoreboard, bus assertions and tests

`timescale 1ns/100ps

module tb_wb_mem_subsystem;

localparam int NUM_BANKS   = 4;
localparam int BANK_WORDS  = 64;
localparam int TOTAL_WORDS = NUM_BANKS * BANK_WORDS;
localparam int IDX_W       = $clog2(TOTAL_WORDS);
localparam int ACK_TIMEOUT = 40;
localparam int BURST_LEN   = 4;

logic                clk;
logic                reset;
wb_mem_pkg::wb_req_t code_req;
wb_mem_pkg::wb_req_t data_req;
wb_mem_pkg::wb_rsp_t code_rsp;
wb_mem_pkg::wb_rsp_t data_rsp;

// Reference copy of the whole memory map with one word per entry
logic [31:0] model_mem [TOTAL_WORDS];

int    errors;
int    tests;
int    failed;
int    errors_at_start;
int    seed;
string cur_test;
logic  hung;
logic  burst_active;

wb_mem_subsystem #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
) dut0 (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_code_req (code_req),
        .o_code_rsp (code_rsp),
        .i_data_req (data_req),
        .o_data_rsp (data_rsp)
);

always #10 clk = ~clk;

`include "tb_wb_tasks.svh"

////////////////////////////////////////////////////////////////////////////
// Bus rules
////////////////////////////////////////////////////////////////////////////

// A master only sees ack while it strobes and never together with the other master
assert property (@(posedge clk) disable iff (reset)
        code_rsp.ack |-> code_req.stb && !data_rsp.ack)
else
begin
        $display("code port saw an ack without its own strobe or alongside the data port");
        errors++;
end

assert property (@(posedge clk) disable iff (reset)
        data_rsp.ack |-> data_req.stb && !code_rsp.ack)
else
begin
        $display("data port saw an ack without its own strobe or alongside the code port");
        errors++;
end

// An err always rides on an ack and only comes back for an address past the map
assert property (@(posedge clk) disable iff (reset)
        code_rsp.err |-> code_rsp.ack && code_req.adr >= 32'(TOTAL_WORDS * 4))
else
begin
        $display("code port saw an err without an ack or for a mapped address");
        errors++;
end

assert property (@(posedge clk) disable iff (reset)
        data_rsp.err |-> data_rsp.ack && data_req.adr >= 32'(TOTAL_WORDS * 4))
else
begin
        $display("data port saw an err without an ack or for a mapped address");
        errors++;
end

// No data ack may slip into a running code burst
assert property (@(posedge clk) disable iff (reset) burst_active |-> !data_rsp.ack)
else
begin
        $display("data port got an ack in the middle of a code burst");
        errors++;
end

////////////////////////////////////////////////////////////////////////////
// Scoreboard and reporting
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] bank_adr(input int bank, input int word);
        return 32'((bank * BANK_WORDS + word) * 4);
endfunction

// Only the byte lanes picked by sel take the new data
function automatic void model_write(input logic [31:0] adr, input logic [3:0] sel,
                                    input logic [31:0] dat);
        logic [31:0]      mask;
        logic [IDX_W-1:0] idx;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        idx  = adr[2 +: IDX_W];
        model_mem[idx] = (model_mem[idx] & ~mask) | (dat & mask);
endfunction

function automatic logic [31:0] model_word(input logic [31:0] adr);
        return model_mem[adr[2 +: IDX_W]];
endfunction

task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
        tests++;
endtask

task automatic finish_test();
        if (errors == errors_at_start)
                $display("test %s: passed", cur_test);
        else
        begin
                $display("test %s: failed with %0d errors", cur_test, errors - errors_at_start);
                failed++;
        end
endtask

task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
                $display("error %s, %s: expected %h, actual %h", cur_test, what, exp, act);
                errors++;
        end
endtask

////////////////////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////////////////////

initial
begin
        logic [31:0]                rdat;
        logic [31:0]                rdat_b;
        logic [31:0]                wdat;
        logic [31:0]                wdat_b;
        logic                       err;
        logic                       err_b;
        logic [BURST_LEN-1:0][31:0] burst_wdat;
        logic [BURST_LEN-1:0][31:0] burst_rdat;
        logic [31:0]                adr_q [$];
        time                        t_code;
        time                        t_data;

        seed         = 45;
        clk          = 1'b0;
        reset        = 1'b1;
        code_req     = idle_req();
        data_req     = idle_req();
        errors       = 0;
        tests        = 0;
        failed       = 0;
        hung         = 1'b0;
        burst_active = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Both sides ask in the same cycle and code wins the first round before they take turns
        start_test("arbitration");
        for (int round = 0; round < 3; round++)
        begin
                wdat   = $random(seed);
                wdat_b = $random(seed);
                fork
                        begin
                                code_access(1'b1, bank_adr(0, 2 * round), 4'hf, wdat, rdat, err);
                                t_code = $time;
                        end
                        begin
                                data_access(1'b1, bank_adr(0, 2 * round + 1), 4'hf, wdat_b,
                                            rdat_b, err_b);
                                t_data = $time;
                        end
                join
                model_write(bank_adr(0, 2 * round), 4'hf, wdat);
                model_write(bank_adr(0, 2 * round + 1), 4'hf, wdat_b);
                check_value("side served first, 1 is data", 32'(round % 2), 32'(t_data < t_code));
                check_value("err flags", 32'h0, 32'({err, err_b}));
        end
        finish_test();

        // Three random words per bank are written by code and read back by data
        start_test("write_read");
        for (int b = 0; b < NUM_BANKS; b++)
        begin
                for (int k = 0; k < 3; k++)
                        adr_q.push_back(bank_adr(b, int'($unsigned($random(seed)) % BANK_WORDS)));
        end
        foreach (adr_q[i])
        begin
                wdat = $random(seed);
                code_access(1'b1, adr_q[i], 4'hf, wdat, rdat, err);
                model_write(adr_q[i], 4'hf, wdat);
        end
        foreach (adr_q[i])
        begin
                data_access(1'b0, adr_q[i], 4'hf, 32'h0, rdat, err);
                check_value("read back", model_word(adr_q[i]), rdat);
        end
        finish_test();

        start_test("byte_lanes");
        wdat = $random(seed);
        data_access(1'b1, bank_adr(3, 17), 4'hf, wdat, rdat, err);
        model_write(bank_adr(3, 17), 4'hf, wdat);
        for (int s = 1; s < 15; s += 3)
        begin
                wdat = $random(seed);
                code_access(1'b1, bank_adr(3, 17), 4'(s), wdat, rdat, err);
                model_write(bank_adr(3, 17), 4'(s), wdat);
                data_access(1'b0, bank_adr(3, 17), 4'hf, 32'h0, rdat, err);
                check_value("merged word", model_word(bank_adr(3, 17)), rdat);
        end
        finish_test();

        // A burst write runs alone and a burst read then runs with a data read arriving mid-burst
        start_test("burst");
        for (int i = 0; i < BURST_LEN; i++)
                burst_wdat[i] = $random(seed);
        code_burst(1'b1, bank_adr(1, 8), burst_wdat, burst_rdat, err, t_code);
        for (int i = 0; i < BURST_LEN; i++)
                model_write(bank_adr(1, 8 + i), 4'hf, burst_wdat[i]);
        burst_active = 1'b1;
        fork
                begin
                        code_burst(1'b0, bank_adr(1, 8), '0, burst_rdat, err, t_code);
                        burst_active = 1'b0;
                end
                begin
                        @(negedge clk);
                        data_access(1'b0, adr_q[0], 4'hf, 32'h0, rdat, err_b);
                        t_data = $time;
                end
        join
        for (int i = 0; i < BURST_LEN; i++)
                check_value("burst beat", burst_wdat[i], burst_rdat[i]);
        check_value("data read during burst", model_word(adr_q[0]), rdat);
        check_value("data served after end of burst", 32'h1, 32'(t_data > t_code));
        finish_test();

        // The write goes one map size above adr_q[0] where a truncating decoder would alias
        start_test("out_of_range");
        wdat = $random(seed);
        code_access(1'b1, adr_q[0] + 32'(TOTAL_WORDS * 4), 4'hf, wdat, rdat, err);
        check_value("code write err", 32'h1, 32'(err));
        data_access(1'b0, 32'hffff_fffc, 4'hf, 32'h0, rdat, err);
        check_value("data read err", 32'h1, 32'(err));
        foreach (adr_q[i])
        begin
                data_access(1'b0, adr_q[i], 4'hf, 32'h0, rdat, err);
                check_value("bank word unchanged", model_word(adr_q[i]), rdat);
        end
        finish_test();

        $display("tests run %0d, passed %0d, failed %0d", tests, tests - failed, failed);
        if (!hung && errors == 0)
        begin
                $display("Simulation finished: PASS");
        end
        else
        begin
                $display("Simulation finished: FAIL");
        end
        $finish;
end

endmodule

// File: compile.f
+incdir+bench
design/wb_mem_pkg.sv
design/wb_arbiter.sv
design/wb_bank_decoder.sv
design/wb_sram_bank.sv
design/wb_resp_collector.sv
design/wb_mem_subsystem.sv
bench/tb_wb_mem_subsystem.sv

// File: design/wb_arbiter.sv
// Round-robin code/data bus arbiter with burst protection and response steering

`timescale 1ns/100ps

module wb_arbiter
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Instruction fetch master
        input  wb_mem_pkg::wb_req_t i_code_req,
        output wb_mem_pkg::wb_rsp_t o_code_rsp,

        // Load/store master
        input  wb_mem_pkg::wb_req_t i_data_req,
        output wb_mem_pkg::wb_rsp_t o_data_rsp,

        // Merged bus towards the decoder
        output wb_mem_pkg::wb_req_t o_bus_req,
        input  wb_mem_pkg::wb_rsp_t i_bus_rsp
);

////////////////////////////////////////////////////////////////////////////
// Owner select FSM
////////////////////////////////////////////////////////////////////////////

// Current and next owner of the shared bus
wb_mem_pkg::arb_sel_e sel_ff;
wb_mem_pkg::arb_sel_e sel_nxt;

// High on the beat that closes a burst or a classic access
logic last_beat;

// A beat only ends on a response, so ack or err with EOB marks the end
assign last_beat = (i_bus_rsp.ack | i_bus_rsp.err) &&
                   (o_bus_req.cti == wb_mem_pkg::CTI_EOB);

always_comb
begin
        // Hold the owner unless one of the hand-over rules fires
        sel_nxt = sel_ff;

        case (sel_ff)
        wb_mem_pkg::CODE:
        begin
                // Hand over after the last beat if data is waiting
                // Also hand over when code has gone idle and data wants the bus
                if (last_beat && i_data_req.stb)
                begin
                        sel_nxt = wb_mem_pkg::DATA;
                end
                else if (!i_code_req.stb && i_data_req.stb)
                begin
                        sel_nxt = wb_mem_pkg::DATA;
                end
        end

        wb_mem_pkg::DATA:
        begin
                // Same rules mirrored for the code side
                if (last_beat && i_code_req.stb)
                begin
                        sel_nxt = wb_mem_pkg::CODE;
                end
                else if (!i_data_req.stb && i_code_req.stb)
                begin
                        sel_nxt = wb_mem_pkg::CODE;
                end
        end
        endcase
end

// Code owns the bus out of reset
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                sel_ff <= wb_mem_pkg::CODE;
        end
        else
        begin
                sel_ff <= sel_nxt;
        end
end

////////////////////////////////////////////////////////////////////////////
// Request mux and response steering
////////////////////////////////////////////////////////////////////////////

// Masters drive registered ports, so a plain 2:1 mux is enough here
assign o_bus_req = (sel_ff == wb_mem_pkg::CODE) ? i_code_req : i_data_req;

// An error also counts as an ack so the master always finishes its beat
assign o_code_rsp.ack = (sel_ff == wb_mem_pkg::CODE) & (i_bus_rsp.ack | i_bus_rsp.err);
assign o_data_rsp.ack = (sel_ff == wb_mem_pkg::DATA) & (i_bus_rsp.ack | i_bus_rsp.err);
assign o_code_rsp.err = (sel_ff == wb_mem_pkg::CODE) & i_bus_rsp.err;
assign o_data_rsp.err = (sel_ff == wb_mem_pkg::DATA) & i_bus_rsp.err;

// Read data is qualified by ack at the master, so both sides get it
assign o_code_rsp.rdat = i_bus_rsp.rdat;
assign o_data_rsp.rdat = i_bus_rsp.rdat;

endmodule

// File: design/wb_bank_decoder.sv
// Bank decoder routing the merged request to one SRAM bank and flagging misses

`timescale 1ns/100ps

module wb_bank_decoder #(
        parameter int NUM_BANKS  = 4,
        parameter int BANK_WORDS = 64
)
(
        // Merged request from the arbiter
        input  wb_mem_pkg::wb_req_t i_bus_req,

        // One request per bank, only the addressed bank is strobed
        output wb_mem_pkg::wb_req_t o_bank_req [NUM_BANKS],

        // Access to an address past the last bank
        output logic                o_miss
);

////////////////////////////////////////////////////////////////////////////
// Address split
////////////////////////////////////////////////////////////////////////////

// Word index over the whole map, then bank number and offset inside it
logic [31:0] word_idx;
logic [31:0] bank_num;
logic [31:0] word_off;
logic        hit;

assign word_idx = i_bus_req.adr >> wb_mem_pkg::ADDR_LSB;
assign bank_num = word_idx / 32'(BANK_WORDS);
assign word_off = word_idx % 32'(BANK_WORDS);

// Anything at or above NUM_BANKS * BANK_WORDS words has no bank behind it
assign hit = (bank_num < 32'(NUM_BANKS));

////////////////////////////////////////////////////////////////////////////
// Per-bank request
////////////////////////////////////////////////////////////////////////////

always_comb
begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
                // Payload fans out to every bank, banks only act on stb
                o_bank_req[b]     = i_bus_req;
                // Banks see a byte address relative to their own base
                o_bank_req[b].adr = word_off << wb_mem_pkg::ADDR_LSB;
                o_bank_req[b].cyc = i_bus_req.cyc & hit & (bank_num == 32'(b));
                o_bank_req[b].stb = i_bus_req.stb & hit & (bank_num == 32'(b));
        end
end

// The miss stays up as long as the master keeps strobing the bad address
assign o_miss = i_bus_req.cyc & i_bus_req.stb & ~hit;

endmodule

// File: design/wb_mem_pkg.sv
// Bus request and response structs, cycle-type enum, arbiter state enum, address constant

package wb_mem_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Bus encodings
        ////////////////////////////////////////////////////////////////////////////

        // Wishbone cycle type tag, carried with every beat of a request
        // Classic accesses are tagged with end of burst, like the core does
        typedef enum logic [2:0] {
                CTI_CLASSIC = 3'b000,
                CTI_INCR    = 3'b010,
                CTI_EOB     = 3'b111
        } wb_cti_e;

        // Which master owns the shared bus
        typedef enum logic {
                CODE = 1'b0,
                DATA = 1'b1
        } arb_sel_e;

        // Byte offset bits dropped from a byte address to get a word index
        localparam int ADDR_LSB = 2;

        ////////////////////////////////////////////////////////////////////////////
        // Bus structs
        ////////////////////////////////////////////////////////////////////////////

        // One master request, held stable by the master until it sees ack
        typedef struct packed {
                logic        cyc;
                logic        stb;
                logic        wen;
                logic [3:0]  sel;
                // Byte address, the low ADDR_LSB bits are ignored by the banks
                logic [31:0] adr;
                logic [31:0] dat;
                wb_cti_e     cti;
        } wb_req_t;

        // One slave response, err is only ever seen together with ack at a master
        typedef struct packed {
                logic        ack;
                logic        err;
                logic [31:0] rdat;
        } wb_rsp_t;

endpackage

// File: design/wb_mem_subsystem.sv
// Shared memory subsystem top level with arbiter, bank decoder, SRAM banks and collector

`timescale 1ns/100ps

module wb_mem_subsystem #(
        parameter int NUM_BANKS  = 4,
        parameter int BANK_WORDS = 64
)
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Instruction fetch master
        input  wb_mem_pkg::wb_req_t i_code_req,
        output wb_mem_pkg::wb_rsp_t o_code_rsp,

        // Load/store master
        input  wb_mem_pkg::wb_req_t i_data_req,
        output wb_mem_pkg::wb_rsp_t o_data_rsp
);

////////////////////////////////////////////////////////////////////////////
// Internal bus
////////////////////////////////////////////////////////////////////////////

wb_mem_pkg::wb_req_t bus_req;
wb_mem_pkg::wb_rsp_t bus_rsp;
wb_mem_pkg::wb_req_t bank_req [NUM_BANKS];
wb_mem_pkg::wb_rsp_t bank_rsp [NUM_BANKS];
logic                miss;

// Merges both masters onto one bus without splitting bursts
wb_arbiter u_arbiter (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_code_req (i_code_req),
        .o_code_rsp (o_code_rsp),
        .i_data_req (i_data_req),
        .o_data_rsp (o_data_rsp),
        .o_bus_req  (bus_req),
        .i_bus_rsp  (bus_rsp)
);

// Picks the bank from the word index, zero latency
wb_bank_decoder #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
) u_decoder (
        .i_bus_req  (bus_req),
        .o_bank_req (bank_req),
        .o_miss     (miss)
);

////////////////////////////////////////////////////////////////////////////
// Banks
////////////////////////////////////////////////////////////////////////////

for (genvar b = 0; b < NUM_BANKS; b++)
begin : g_bank
        wb_sram_bank #(
                .BANK_WORDS (BANK_WORDS)
        ) u_bank (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .i_req   (bank_req[b]),
                .o_rsp   (bank_rsp[b])
        );
end

// Joins bank responses and adds the error for unmapped addresses
wb_resp_collector #(
        .NUM_BANKS (NUM_BANKS)
) u_collector (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_bank_rsp (bank_rsp),
        .i_miss     (miss),
        .o_bus_rsp  (bus_rsp)
);

endmodule

// File: design/wb_resp_collector.sv
// Response collector merging bank responses and the out-of-range error

`timescale 1ns/100ps

module wb_resp_collector #(
        parameter int NUM_BANKS = 4
)
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Responses from every bank, at most one acks at a time
        input  wb_mem_pkg::wb_rsp_t i_bank_rsp [NUM_BANKS],

        // Strobed access with no bank behind it
        input  logic                i_miss,

        // Merged response back to the arbiter
        output wb_mem_pkg::wb_rsp_t o_bus_rsp
);

////////////////////////////////////////////////////////////////////////////
// Out-of-range error
////////////////////////////////////////////////////////////////////////////

logic miss_err_ff;

// One err pulse, a cycle after the miss, like a bank's ack timing
// The miss is still up while the err is out, so it must not retrigger
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                miss_err_ff <= 1'b0;
        end
        else
        begin
                miss_err_ff <= i_miss && !miss_err_ff;
        end
end

////////////////////////////////////////////////////////////////////////////
// Merge
////////////////////////////////////////////////////////////////////////////

always_comb
begin
        o_bus_rsp.ack  = 1'b0;
        o_bus_rsp.err  = miss_err_ff;
        o_bus_rsp.rdat = '0;

        // AND-OR mux, read data only passes from the bank that acks
        for (int b = 0; b < NUM_BANKS; b++)
        begin
                o_bus_rsp.ack  = o_bus_rsp.ack | i_bank_rsp[b].ack;
                o_bus_rsp.err  = o_bus_rsp.err | i_bank_rsp[b].err;
                o_bus_rsp.rdat = o_bus_rsp.rdat | ({32{i_bank_rsp[b].ack}} & i_bank_rsp[b].rdat);
        end
end

endmodule

// File: design/wb_sram_bank.sv
// Word-addressed SRAM bank with byte-lane writes, registered read data and ack

`timescale 1ns/100ps

module wb_sram_bank #(
        parameter int BANK_WORDS = 64
)
(
        input  logic                i_clk,
        input  logic                i_reset,

        // Request from the decoder, adr is relative to the bank base
        input  wb_mem_pkg::wb_req_t i_req,
        output wb_mem_pkg::wb_rsp_t o_rsp
);

// Word index width, kept at one bit for a single-word bank
localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

////////////////////////////////////////////////////////////////////////////
// Handshake
////////////////////////////////////////////////////////////////////////////

logic             ack_ff;
logic             ack_nxt;
logic             in_burst;
logic [IDX_W-1:0] cur_idx;
logic [IDX_W-1:0] rd_idx;
logic [31:0]      mem [BANK_WORDS];
logic [31:0]      rdat_ff;

// Current beat address as a word index inside this bank
assign cur_idx = i_req.adr[wb_mem_pkg::ADDR_LSB +: IDX_W];

// Non-final burst beat that is completing in this cycle
assign in_burst = ack_ff && (i_req.cti == wb_mem_pkg::CTI_INCR);

// New access acks one cycle late, a burst keeps ack up for every held beat
assign ack_nxt = i_req.cyc && i_req.stb && (!ack_ff || in_burst);

// During a burst the next beat's word is read ahead of its address
// A burst is expected not to run past the end of the bank
assign rd_idx = in_burst ? cur_idx + IDX_W'(1) : cur_idx;

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                ack_ff <= 1'b0;
        end
        else
        begin
                ack_ff <= ack_nxt;
        end
end

////////////////////////////////////////////////////////////////////////////
// Storage
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        // Writes land on the edge where the beat transfers
        if (ack_ff && i_req.stb && i_req.wen)
        begin
                for (int l = 0; l < 4; l++)
                begin
                        if (i_req.sel[l])
                        begin
                                mem[cur_idx][l*8 +: 8] <= i_req.dat[l*8 +: 8];
                        end
                end
        end

        // Read data is captured on the same edge that raises ack
        if (ack_nxt)
        begin
                rdat_ff <= mem[rd_idx];
        end
end

// A bank never reports an error on its own
assign o_rsp.ack  = ack_ff;
assign o_rsp.err  = 1'b0;
assign o_rsp.rdat = rdat_ff;

endmodule
